/* include/alloc_settings.svh */
// Sizes for the allocator RTL and its testbench
// ALLOC_NUM_PTRS must equal 2**ALLOC_PTR_WID

`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// Buffer pool
`define ALLOC_NUM_PTRS 16
`define ALLOC_PTR_WID 4

// Length of one buffer, up to ALLOC_BUF_SIZE bytes
`define ALLOC_BUF_SIZE 64
`define ALLOC_LEN_WID 7

// Frame limit and a size width with headroom above it
`define ALLOC_MAX_FRAME_SIZE 256
`define ALLOC_FRAME_SIZE_WID 10

// Register strobe bus
`define ALLOC_REG_ADDR_WID 2
`define ALLOC_REG_DATA_WID 32

`endif

/* source/alloc_pkg.sv */
// Allocator types, sized from the settings header
// Register map is four words, no byte addressing

`include "alloc_settings.svh"

package alloc_pkg;

    // Buffer pointer and lengths
    typedef logic [`ALLOC_PTR_WID-1:0]        ptr_t;
    typedef logic [`ALLOC_LEN_WID-1:0]        len_t;
    typedef logic [`ALLOC_FRAME_SIZE_WID-1:0] frame_size_t;

    // One extra bit so a full pool of 16 fits
    typedef logic [`ALLOC_PTR_WID:0]          count_t;

    // Descriptor, one per buffer, 12 bits
    typedef struct packed {
        len_t len;
        logic eof;
        ptr_t next;
    } desc_t;

    // --------------------
    // Register addresses
    // --------------------
    typedef enum logic [`ALLOC_REG_ADDR_WID-1:0] {
        REG_CTRL   = 2'd0,  // bit 0 enable, bit 1 soft reset
        REG_STATUS = 2'd1,  // bit 0 init_done, free count from bit 8
        REG_FRAMES = 2'd2,
        REG_ERRORS = 2'd3
    } reg_addr_e;

endpackage

/* source/alloc_ram.sv */
// Simple dual-port RAM, one write and one registered read port
// Read of a word written in the same cycle returns the old word

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_ram #(
    parameter type word_t = alloc_pkg::ptr_t,
    parameter int  DEPTH  = `ALLOC_NUM_PTRS
) (
    input  logic            clk,
    input  logic            wr,
    input  alloc_pkg::ptr_t wr_addr,
    input  word_t           wr_data,
    input  alloc_pkg::ptr_t rd_addr,
    output word_t           rd_data
);

    // Contents owned by the writers
    word_t mem [DEPTH];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One-cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/alloc_free_pool.sv */
// Free-pointer FIFO with a show-ahead head, refilled with every pointer after reset
// Push and pop are ignored until init_done; caller must check empty and full

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_free_pool (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  alloc_pkg::ptr_t   push_ptr,
    input  logic              pop,
    output alloc_pkg::ptr_t   head,
    output logic              empty,
    output logic              full,
    output alloc_pkg::count_t count,
    output logic              init_done
);
    import alloc_pkg::*;

    ptr_t head_idx;
    ptr_t tail_idx;
    ptr_t rd_idx;
    ptr_t wr_data;
    ptr_t ram_q;
    ptr_t byp_ptr;
    logic byp_sel;
    logic filling;
    logic do_push;
    logic do_pop;

    // --------------------
    // Write and read side
    // --------------------
    // Fill walks the tail, so each pointer lands in its own slot
    assign filling = !init_done;
    assign do_push = filling || (push && !full);
    assign do_pop  = init_done && pop && !empty;
    assign wr_data = filling ? tail_idx : push_ptr;

    // Look one ahead on a pop so the next head is there a cycle later
    assign rd_idx = do_pop ? ptr_t'(head_idx + 1'b1) : head_idx;

    alloc_ram #(
        .word_t ( ptr_t ),
        .DEPTH  ( `ALLOC_NUM_PTRS )
    ) u_ptr_ram (
        .clk,
        .wr      ( do_push ),
        .wr_addr ( tail_idx ),
        .wr_data ( wr_data ),
        .rd_addr ( rd_idx ),
        .rd_data ( ram_q )
    );

    // Push into the slot being read, RAM would return stale data
    always_ff @(posedge clk) begin
        byp_ptr <= wr_data;
    end

    assign head  = byp_sel ? byp_ptr : ram_q;
    assign empty = (count == '0);
    assign full  = (count == count_t'(`ALLOC_NUM_PTRS));

    // --------------------
    // Indices and count
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            head_idx  <= '0;
            tail_idx  <= '0;
            count     <= '0;
            byp_sel   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            byp_sel <= do_push && (tail_idx == rd_idx);
            if (do_push) begin
                tail_idx <= tail_idx + 1'b1;
            end
            if (do_pop) begin
                head_idx <= head_idx + 1'b1;
            end
            count <= count + count_t'(do_push) - count_t'(do_pop);
            // Last fill write, pool holds every pointer next cycle
            if (filling && tail_idx == ptr_t'(`ALLOC_NUM_PTRS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

endmodule

/* source/alloc_sg_core.sv */
// Single-context scatter/gather allocator, pointers and descriptors only
// Descriptor read in the cycle of its write returns the old descriptor

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_sg_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    // Scatter side
    input  logic                   store_req,
    input  logic                   store_eof,
    input  alloc_pkg::len_t        store_len,
    output logic                   store_rdy,
    output alloc_pkg::ptr_t        store_ptr,
    // Frame completion
    output logic                   frame_valid,
    output logic                   frame_error,
    output alloc_pkg::ptr_t        frame_ptr,
    output alloc_pkg::frame_size_t frame_size,
    // Gather side
    input  logic                   load_req,
    input  alloc_pkg::ptr_t        load_ptr,
    output logic                   load_valid,
    output logic                   load_eof,
    output alloc_pkg::len_t        load_len,
    output alloc_pkg::ptr_t        load_next,
    // Recycle side
    input  logic                   recycle_req,
    input  alloc_pkg::ptr_t        recycle_ptr,
    output logic                   recycle_rdy,
    output logic                   recycle_ack,
    // Status
    output logic                   init_done,
    output alloc_pkg::count_t      free_count
);
    import alloc_pkg::*;

    ptr_t        pool_head;
    logic        pool_empty;
    logic        pool_full;
    count_t      pool_count;
    logic        pool_init;
    logic        pool_pop;
    logic        held_valid;
    logic        store_acc;
    logic        recycle_acc;
    logic        in_frame;
    ptr_t        first_ptr;
    frame_size_t run_size;
    frame_size_t size_base;
    frame_size_t size_next;
    logic [`ALLOC_FRAME_SIZE_WID:0] size_sum;
    desc_t       wr_desc;
    desc_t       rd_desc;
    desc_t       load_desc;
    logic        load_vld_s1;

    // --------------------
    // Pointer supply
    // --------------------
    alloc_free_pool u_free_pool (
        .clk,
        .rst,
        .push      ( recycle_acc ),
        .push_ptr  ( recycle_ptr ),
        .pop       ( pool_pop ),
        .head      ( pool_head ),
        .empty     ( pool_empty ),
        .full      ( pool_full ),
        .count     ( pool_count ),
        .init_done ( pool_init )
    );

    assign store_rdy   = en && init_done && held_valid;
    assign store_acc   = store_req && store_rdy;
    // Refill the held slot, or replace it as a store consumes it
    assign pool_pop    = pool_init && !pool_empty && (store_acc || !held_valid);
    assign recycle_rdy = init_done && !pool_full;
    assign recycle_acc = recycle_req && recycle_rdy;
    // Held pointer counts as free
    assign free_count  = pool_count + count_t'(held_valid);

    // --------------------
    // Descriptors
    // --------------------
    // Next is the pool head, which becomes the following store_ptr
    assign wr_desc = '{len: store_len, eof: store_eof, next: pool_head};

    alloc_ram #(
        .word_t ( desc_t ),
        .DEPTH  ( `ALLOC_NUM_PTRS )
    ) u_desc_ram (
        .clk,
        .wr      ( store_acc ),
        .wr_addr ( store_ptr ),
        .wr_data ( wr_desc ),
        .rd_addr ( load_ptr ),
        .rd_data ( rd_desc )
    );

    // Running sum, saturates instead of wrapping
    assign size_base = in_frame ? run_size : '0;
    assign size_sum  = {1'b0, size_base} + store_len;
    assign size_next = size_sum[`ALLOC_FRAME_SIZE_WID] ? '1
                                                        : size_sum[`ALLOC_FRAME_SIZE_WID-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid  <= 1'b0;
            init_done   <= 1'b0;
            in_frame    <= 1'b0;
            frame_valid <= 1'b0;
            recycle_ack <= 1'b0;
            load_vld_s1 <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            if (pool_pop) begin
                held_valid <= 1'b1;
            end else if (store_acc) begin
                held_valid <= 1'b0;
            end
            // Sticky, exhaustion does not clear it
            if (pool_init && held_valid) begin
                init_done <= 1'b1;
            end
            if (store_acc) begin
                in_frame <= !store_eof;
            end
            frame_valid <= store_acc && store_eof;
            recycle_ack <= recycle_acc;
            // Valid rides alongside the RAM read
            load_vld_s1 <= load_req;
            load_valid  <= load_vld_s1;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (pool_pop) begin
            store_ptr <= pool_head;
        end
        if (store_acc && store_eof) begin
            frame_ptr   <= in_frame ? first_ptr : store_ptr;
            frame_size  <= size_next;
            frame_error <= size_next > frame_size_t'(`ALLOC_MAX_FRAME_SIZE);
        end else if (store_acc) begin
            run_size <= size_next;
            if (!in_frame) begin
                first_ptr <= store_ptr;
            end
        end
        load_desc <= rd_desc;
    end

    assign load_len  = load_desc.len;
    assign load_eof  = load_desc.eof;
    assign load_next = load_desc.next;

endmodule

/* source/alloc_ctrl_regs.sv */
// Control, status and counter registers on a strobe bus
// Writes take effect at once, reads return one cycle after reg_rd

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_ctrl_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           reg_wr,
    input  logic                           reg_rd,
    input  alloc_pkg::reg_addr_e           reg_addr,
    input  logic [`ALLOC_REG_DATA_WID-1:0] reg_wdata,
    output logic [`ALLOC_REG_DATA_WID-1:0] reg_rdata,
    output logic                           reg_rvalid,
    output logic                           ctrl_en,
    output logic                           ctrl_reset,
    input  logic                           init_done,
    input  alloc_pkg::count_t              free_count,
    input  logic                           frame_valid,
    input  logic                           frame_error
);
    import alloc_pkg::*;

    logic                           ctrl_wr;
    logic [`ALLOC_REG_DATA_WID-1:0] frame_cnt;
    logic [`ALLOC_REG_DATA_WID-1:0] error_cnt;
    logic [`ALLOC_REG_DATA_WID-1:0] rd_mux;

    assign ctrl_wr = reg_wr && (reg_addr == REG_CTRL);

    // --------------------
    // Control and counters
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en    <= 1'b0;
            ctrl_reset <= 1'b0;
            frame_cnt  <= '0;
            error_cnt  <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            // Soft reset also leaves the core disabled
            if (ctrl_wr) begin
                ctrl_en <= reg_wdata[0] && !reg_wdata[1];
            end
            ctrl_reset <= ctrl_wr && reg_wdata[1];
            // Both counters stick at all ones
            if (frame_valid && frame_cnt != '1) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (frame_valid && frame_error && error_cnt != '1) begin
                error_cnt <= error_cnt + 1'b1;
            end
            reg_rvalid <= reg_rd;
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            REG_CTRL: begin
                rd_mux[0] = ctrl_en;
                rd_mux[1] = ctrl_reset;
            end
            REG_STATUS: begin
                rd_mux[0] = init_done;
                rd_mux[8 +: $bits(count_t)] = free_count;
            end
            REG_FRAMES: rd_mux = frame_cnt;
            REG_ERRORS: rd_mux = error_cnt;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

/* source/alloc_sg_top.sv */
// Allocator top, register block in front of one scatter/gather core
// Soft reset restarts the core only, counters keep their values

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_sg_top (
    input  logic                           clk,
    input  logic                           rst,
    // Register bus
    input  logic                           reg_wr,
    input  logic                           reg_rd,
    input  alloc_pkg::reg_addr_e           reg_addr,
    input  logic [`ALLOC_REG_DATA_WID-1:0] reg_wdata,
    output logic [`ALLOC_REG_DATA_WID-1:0] reg_rdata,
    output logic                           reg_rvalid,
    // Scatter side
    input  logic                           store_req,
    input  logic                           store_eof,
    input  alloc_pkg::len_t                store_len,
    output logic                           store_rdy,
    output alloc_pkg::ptr_t                store_ptr,
    // Frame completion
    output logic                           frame_valid,
    output logic                           frame_error,
    output alloc_pkg::ptr_t                frame_ptr,
    output alloc_pkg::frame_size_t         frame_size,
    // Gather side
    input  logic                           load_req,
    input  alloc_pkg::ptr_t                load_ptr,
    output logic                           load_valid,
    output logic                           load_eof,
    output alloc_pkg::len_t                load_len,
    output alloc_pkg::ptr_t                load_next,
    // Recycle side
    input  logic                           recycle_req,
    input  alloc_pkg::ptr_t                recycle_ptr,
    output logic                           recycle_rdy,
    output logic                           recycle_ack,
    output logic                           init_done
);
    import alloc_pkg::*;

    logic   ctrl_en;
    logic   ctrl_reset;
    logic   core_rst;
    count_t free_count;

    // Core restarts on either reset
    assign core_rst = rst || ctrl_reset;

    // --------------------
    // Register block
    // --------------------
    alloc_ctrl_regs u_ctrl_regs (
        .clk,
        .rst,
        .reg_wr,
        .reg_rd,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .reg_rvalid,
        .ctrl_en,
        .ctrl_reset,
        .init_done,
        .free_count,
        .frame_valid,
        .frame_error
    );

    // --------------------
    // Allocator core
    // --------------------
    alloc_sg_core u_sg_core (
        .clk,
        .rst ( core_rst ),
        .en  ( ctrl_en ),
        .store_req,
        .store_eof,
        .store_len,
        .store_rdy,
        .store_ptr,
        .frame_valid,
        .frame_error,
        .frame_ptr,
        .frame_size,
        .load_req,
        .load_ptr,
        .load_valid,
        .load_eof,
        .load_len,
        .load_next,
        .recycle_req,
        .recycle_ptr,
        .recycle_rdy,
        .recycle_ack,
        .init_done,
        .free_count
    );

endmodule

/* tests/alloc_sg_assert.sv */
// Timing properties of the allocator ports, bound into alloc_sg_top
// Core properties are cut off during core_rst, register ones during rst

`timescale 1ns/1ps

module alloc_sg_assert (
    input logic clk,
    input logic rst,
    input logic core_rst,
    input logic init_done,
    input logic store_req,
    input logic store_eof,
    input logic store_rdy,
    input logic frame_valid,
    input logic recycle_req,
    input logic recycle_rdy,
    input logic recycle_ack,
    input logic load_req,
    input logic load_valid,
    input logic reg_rd,
    input logic reg_rvalid
);

    // --------------------
    // Ready levels
    // --------------------
    // Both ready levels and init_done start low after any core reset
    ready_low_after_reset: assert property (@(posedge clk)
        core_rst |=> !(store_rdy || recycle_rdy || init_done))
        else $error("Ready level or init_done high right after core reset");

    // --------------------
    // Response timing
    // --------------------
    // Ack exactly one cycle after an accepted recycle, never otherwise
    recycle_ack_after: assert property (@(posedge clk) disable iff (core_rst)
        (recycle_req && recycle_rdy) |=> recycle_ack)
        else $error("recycle_ack missing after accepted recycle");
    recycle_ack_only: assert property (@(posedge clk) disable iff (core_rst)
        recycle_ack |-> $past(recycle_req && recycle_rdy))
        else $error("recycle_ack without accepted recycle");

    frame_after_eof: assert property (@(posedge clk) disable iff (core_rst)
        (store_req && store_rdy && store_eof) |=> frame_valid)
        else $error("frame_valid missing after accepted eof");
    frame_only: assert property (@(posedge clk) disable iff (core_rst)
        frame_valid |-> $past(store_req && store_rdy && store_eof))
        else $error("frame_valid without accepted eof");

    // Two-stage gather pipeline
    load_two_cycles: assert property (@(posedge clk) disable iff (core_rst)
        load_req |-> ##2 load_valid)
        else $error("load_valid not two cycles after load_req");

    reg_read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        reg_rd |=> reg_rvalid)
        else $error("reg_rvalid not one cycle after reg_rd");

endmodule

bind alloc_sg_top alloc_sg_assert u_sg_assert (
    .clk         ( clk ),
    .rst         ( rst ),
    .core_rst    ( core_rst ),
    .init_done   ( init_done ),
    .store_req   ( store_req ),
    .store_eof   ( store_eof ),
    .store_rdy   ( store_rdy ),
    .frame_valid ( frame_valid ),
    .recycle_req ( recycle_req ),
    .recycle_rdy ( recycle_rdy ),
    .recycle_ack ( recycle_ack ),
    .load_req    ( load_req ),
    .load_valid  ( load_valid ),
    .reg_rd      ( reg_rd ),
    .reg_rvalid  ( reg_rvalid )
);

/* tests/alloc_sg_tb.sv */
// Allocator testbench, drives on rising edges and samples on falling edges
// Expects the pool to hand out pointers in FIFO order, 0 to 15 after each reset

`timescale 1ns/1ps
`include "alloc_settings.svh"

module alloc_sg_tb;
    import alloc_pkg::*;

    // Handshake selectors for the wait task
    localparam int SIG_STORE_RDY   = 0;
    localparam int SIG_INIT_DONE   = 1;
    localparam int SIG_LOAD_VALID  = 2;
    localparam int SIG_RECYCLE_RDY = 3;
    localparam int SIG_RECYCLE_ACK = 4;
    localparam int SIG_REG_RVALID  = 5;
    localparam int WAIT_LIMIT      = 64;

    // Run length from the operation counts of all tests
    localparam int INIT_CYCLES     = 10 + `ALLOC_NUM_PTRS + 8;
    localparam int WATCHDOG_CYCLES = 2 * (2 * INIT_CYCLES + 27 * 3 + 24 * 4 + 3 * 4 + 20 * 3) + 100;

    logic                           clk;
    logic                           rst;
    logic                           reg_wr;
    logic                           reg_rd;
    reg_addr_e                      reg_addr;
    logic [`ALLOC_REG_DATA_WID-1:0] reg_wdata;
    logic [`ALLOC_REG_DATA_WID-1:0] reg_rdata;
    logic                           reg_rvalid;
    logic                           store_req;
    logic                           store_eof;
    len_t                           store_len;
    logic                           store_rdy;
    ptr_t                           store_ptr;
    logic                           frame_valid;
    logic                           frame_error;
    ptr_t                           frame_ptr;
    frame_size_t                    frame_size;
    logic                           load_req;
    ptr_t                           load_ptr;
    logic                           load_valid;
    logic                           load_eof;
    len_t                           load_len;
    ptr_t                           load_next;
    logic                           recycle_req;
    ptr_t                           recycle_ptr;
    logic                           recycle_rdy;
    logic                           recycle_ack;
    logic                           init_done;

    // --------------------
    // Reference model
    // --------------------
    // Front of the queue is the pointer the core holds
    ptr_t        free_q[$];
    len_t        model_len [`ALLOC_NUM_PTRS];
    logic        model_eof [`ALLOC_NUM_PTRS];
    ptr_t        model_next [`ALLOC_NUM_PTRS];
    logic        model_next_known [`ALLOC_NUM_PTRS];
    logic        open_frame;
    ptr_t        model_first;
    int          model_size;
    int          frames_exp;
    int          errors_exp;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    logic [7:0]  lfsr_state;

    alloc_sg_top u_alloc_sg_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic signal_level(input int sel);
        case (sel)
            SIG_STORE_RDY:   return store_rdy;
            SIG_INIT_DONE:   return init_done;
            SIG_LOAD_VALID:  return load_valid;
            SIG_RECYCLE_RDY: return recycle_rdy;
            SIG_RECYCLE_ACK: return recycle_ack;
            SIG_REG_RVALID:  return reg_rvalid;
            default:         return 1'b0;
        endcase
    endfunction

    // Returns on the first falling edge where the level is seen
    task automatic wait_for_level(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (signal_level(sel) !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (signal_level(sel) !== level) begin
            $display("Timeout: %s did not reach %0b within %0d cycles", what, level, WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic refill_model();
        int i;
        free_q.delete();
        for (i = 0; i < `ALLOC_NUM_PTRS; i++) begin
            free_q.push_back(ptr_t'(i));
        end
        open_frame = 1'b0;
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
    endtask

    // --------------------
    // Bus tasks
    // --------------------
    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd   <= 1'b0;
        wait_for_level(SIG_REG_RVALID, 1'b1, "reg_rvalid");
        data = reg_rdata;
    endtask

    // One buffer, with the frame report checked on eof
    task automatic store_buf(input len_t len, input logic eof, output ptr_t ptr);
        ptr_t exp_ptr;
        wait_for_level(SIG_STORE_RDY, 1'b1, "store_rdy");
        ptr = store_ptr;
        exp_ptr = (free_q.size() > 0) ? free_q[0] : '0;
        check_value("store_ptr", exp_ptr, ptr);
        if (free_q.size() > 0) begin
            void'(free_q.pop_front());
        end
        model_len[exp_ptr] = len;
        model_eof[exp_ptr] = eof;
        model_next_known[exp_ptr] = (free_q.size() > 0);
        if (free_q.size() > 0) begin
            model_next[exp_ptr] = free_q[0];
        end
        if (!open_frame) begin
            model_first = exp_ptr;
            model_size  = 0;
        end
        model_size += int'(len);
        open_frame = !eof;
        @(posedge clk);
        store_req <= 1'b1;
        store_len <= len;
        store_eof <= eof;
        @(posedge clk);
        store_req <= 1'b0;
        store_eof <= 1'b0;
        @(negedge clk);
        check_value("frame_valid", eof, frame_valid);
        if (eof) begin
            frames_exp++;
            if (model_size > `ALLOC_MAX_FRAME_SIZE) begin
                errors_exp++;
            end
            check_value("frame_ptr", model_first, frame_ptr);
            check_value("frame_size", model_size, frame_size);
            check_value("frame_error", model_size > `ALLOC_MAX_FRAME_SIZE, frame_error);
        end
    endtask

    task automatic load_check(input ptr_t ptr, output ptr_t next);
        @(posedge clk);
        load_req <= 1'b1;
        load_ptr <= ptr;
        @(posedge clk);
        load_req <= 1'b0;
        wait_for_level(SIG_LOAD_VALID, 1'b1, "load_valid");
        next = load_next;
        check_value("load_len", model_len[ptr], load_len);
        check_value("load_eof", model_eof[ptr], load_eof);
        if (model_next_known[ptr]) begin
            check_value("load_next", model_next[ptr], load_next);
        end
    endtask

    task automatic recycle_buf(input ptr_t ptr);
        wait_for_level(SIG_RECYCLE_RDY, 1'b1, "recycle_rdy");
        @(posedge clk);
        recycle_req <= 1'b1;
        recycle_ptr <= ptr;
        @(posedge clk);
        recycle_req <= 1'b0;
        wait_for_level(SIG_RECYCLE_ACK, 1'b1, "recycle_ack");
        free_q.push_back(ptr);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin : main
        logic [31:0] rdata;
        logic [31:0] bits;
        ptr_t        ptr;
        ptr_t        next;
        ptr_t        frame_ptrs[3];
        ptr_t        owned[$];
        len_t        len;
        int          i;
        int          n;
        rst         = 1'b1;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = REG_CTRL;
        reg_wdata   = '0;
        store_req   = 1'b0;
        store_eof   = 1'b0;
        store_len   = '0;
        load_req    = 1'b0;
        load_ptr    = '0;
        recycle_req = 1'b0;
        recycle_ptr = '0;
        lfsr_state  = 8'd76;
        check_count = 0;
        error_count = 0;
        frames_exp  = 0;
        errors_exp  = 0;
        refill_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Init, no stores before enable
        start_test();
        wait_for_level(SIG_INIT_DONE, 1'b1, "init_done");
        check_value("store_rdy", 0, store_rdy);
        reg_read(REG_STATUS, rdata);
        check_value("status.init_done", 1, rdata[0]);
        check_value("status.free_count", `ALLOC_NUM_PTRS, rdata[8 +: $bits(count_t)]);
        reg_write(REG_CTRL, 32'h1);
        reg_read(REG_CTRL, rdata);
        check_value("ctrl.enable", 1, rdata[0]);
        end_test("1 init and status");

        // Three-buffer frame, LFSR lengths 1 to 64
        start_test();
        for (i = 0; i < 3; i++) begin
            random_bits(6, bits);
            len = len_t'(bits[5:0]) + len_t'(1);
            store_buf(len, i == 2, frame_ptrs[i]);
        end
        check_value("distinct pointers", 1, frame_ptrs[0] != frame_ptrs[1] &&
                    frame_ptrs[1] != frame_ptrs[2] && frame_ptrs[0] != frame_ptrs[2]);
        reg_read(REG_FRAMES, rdata);
        check_value("reg_frames", frames_exp, rdata);
        end_test("2 scatter linking");

        // Follow the chain back
        start_test();
        for (i = 0; i < 3; i++) begin
            load_check(frame_ptrs[i], next);
            if (i < 2) begin
                check_value("chain next", frame_ptrs[i + 1], next);
            end
        end
        end_test("3 gather chain");

        // Drain the pool, then give everything back
        start_test();
        for (i = 0; i < 3; i++) begin
            recycle_buf(frame_ptrs[i]);
        end
        reg_read(REG_STATUS, rdata);
        check_value("status.free_count", `ALLOC_NUM_PTRS, rdata[8 +: $bits(count_t)]);
        owned.delete();
        n = 0;
        while (store_rdy && n < `ALLOC_NUM_PTRS + 4) begin
            random_bits(4, bits);
            len = len_t'(bits[3:0]) + len_t'(1);
            store_buf(len, (n % 4) == 3, ptr);
            owned.push_back(ptr);
            n++;
        end
        check_value("stores before exhaustion", `ALLOC_NUM_PTRS, n);
        reg_read(REG_STATUS, rdata);
        check_value("status.free_count", 0, rdata[8 +: $bits(count_t)]);
        foreach (owned[j]) begin
            recycle_buf(owned[j]);
        end
        wait_for_level(SIG_STORE_RDY, 1'b1, "store_rdy");
        reg_read(REG_STATUS, rdata);
        check_value("status.free_count", `ALLOC_NUM_PTRS, rdata[8 +: $bits(count_t)]);
        end_test("4 exhaustion and recycle");

        // Five full buffers, 320 bytes
        start_test();
        owned.delete();
        for (i = 0; i < 5; i++) begin
            store_buf(len_t'(`ALLOC_BUF_SIZE), i == 4, ptr);
            owned.push_back(ptr);
        end
        reg_read(REG_ERRORS, rdata);
        check_value("reg_errors", errors_exp, rdata);
        reg_read(REG_FRAMES, rdata);
        check_value("reg_frames", frames_exp, rdata);
        foreach (owned[j]) begin
            recycle_buf(owned[j]);
        end
        end_test("5 oversize frame");

        // Soft reset with two buffers still owned
        start_test();
        store_buf(len_t'(8), 1'b0, ptr);
        store_buf(len_t'(9), 1'b0, ptr);
        reg_write(REG_CTRL, 32'h3);
        wait_for_level(SIG_INIT_DONE, 1'b0, "init_done low");
        check_value("store_rdy", 0, store_rdy);
        wait_for_level(SIG_INIT_DONE, 1'b1, "init_done");
        refill_model();
        reg_read(REG_CTRL, rdata);
        check_value("ctrl.enable", 0, rdata[0]);
        reg_write(REG_CTRL, 32'h1);
        reg_read(REG_STATUS, rdata);
        check_value("status.init_done", 1, rdata[0]);
        check_value("status.free_count", `ALLOC_NUM_PTRS, rdata[8 +: $bits(count_t)]);
        // Pool restarts at pointer 0
        store_buf(len_t'(4), 1'b0, ptr);
        end_test("6 soft reset");

        $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
source/alloc_pkg.sv
source/alloc_ram.sv
source/alloc_free_pool.sv
source/alloc_sg_core.sv
source/alloc_ctrl_regs.sv
source/alloc_sg_top.sv
tests/alloc_sg_assert.sv
tests/alloc_sg_tb.sv

/* Makefile */
# Verilator build and run of the allocator testbench
TOP := alloc_sg_tb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee run.log
	grep -q "^NO ERRORS$$" run.log

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)
	verilator --lint-only -Wall -f files.f --top-module alloc_sg_top

clean:
	rm -rf obj_dir run.log

.PHONY: all run lint clean
